// File: include/sd_load_defines.svh
`ifndef SD_LOAD_DEFINES_SVH
`define SD_LOAD_DEFINES_SVH

// sd card sector geometry
`define SD_SECTOR_WORDS 256              // 512 bytes packed into 16-bit words

// load job
`define SD_SEC_NUM      3                // sectors read per load
`define SD_START_SEC    32'h0000_0100    // first sector address
`define SD_MAX_WORDS    700              // words kept, rest of last sector dropped

// memory side
`define SD_BURST_LEN    16               // words per memory burst
`define SD_FIFO_DEPTH   32               // two bursts of buffering
`define SD_ADDR_W       24               // memory word address width

// SD_MAX_WORDS must not exceed SD_SEC_NUM * SD_SECTOR_WORDS,
// otherwise flush comes with fewer words than expected
// and SD_FIFO_DEPTH has to stay a power of two

`endif

// File: hw/sd_load_pkg.sv
`default_nettype none

package sd_load_pkg;

    // sd command index, only single block read is issued
    typedef enum logic [5:0] {
        CMD_READ_SINGLE = 6'd17
    } sd_cmd_e;

    typedef enum logic [2:0] {
        SPI_IDLE,                       // cs high, waiting for a request
        SPI_CMD,                        // shifting out the 6 command bytes
        SPI_R1,                         // polling for r1 = 0x00
        SPI_TOKEN,                      // polling for start token 0xfe
        SPI_DATA,                       // 512 data bytes
        SPI_CRC,                        // two crc bytes, discarded
        SPI_GAP                         // one idle byte before releasing cs
    } spi_state_e;

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_REQ,
        LD_WAIT,
        LD_DONE
    } load_state_e;

    typedef enum logic {
        BW_IDLE,
        BW_BURST
    } bw_state_e;

endpackage

`default_nettype wire

// File: hw/sd_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface sd_rd_if;

    logic        rd_start;              // one cycle pulse, starts a sector read
    logic [31:0] rd_sec_addr;           // sector address
    logic        rd_busy;               // reader working
    logic        rd_val_en;             // word valid
    logic [15:0] rd_val_data;           // word, first byte in the msbs
    logic        rd_ready;              // loader can take the word

    modport loader (
        output rd_start,
        output rd_sec_addr,
        output rd_ready,
        input  rd_busy,
        input  rd_val_en,
        input  rd_val_data
    );

    modport reader (
        input  rd_start,
        input  rd_sec_addr,
        input  rd_ready,
        output rd_busy,
        output rd_val_en,
        output rd_val_data
    );

endinterface

`default_nettype wire

// File: hw/sd_spi_reader.sv
`timescale 1ns/1ps
`default_nettype none
`include "sd_load_defines.svh"

module sd_spi_reader (
    input  wire         sys_clk,
    input  wire         rst_n,
    sd_rd_if.reader     rd,
    input  wire         sd_miso,
    output logic        sd_clk,             // idles low in spi mode 0
    output logic        sd_cs,
    output logic        sd_mosi
);

    localparam logic [9:0] DATA_LAST = 10'(`SD_SECTOR_WORDS * 2 - 1);

    sd_load_pkg::spi_state_e state;
    logic [2:0]  bit_cnt;
    logic [7:0]  shift_sr;                  // tx out of the msb while rx enters at the lsb
    logic [7:0]  hi_byte;                   // first byte of the current word
    logic [47:0] cmd_sr;
    logic [9:0]  byte_cnt;
    logic        sh_on;                     // a byte is on the wire
    logic        busy;
    logic        val_en;
    logic [15:0] val_data;
    logic        byte_ok;
    logic        byte_end;
    logic        launch;
    logic [7:0]  tx_byte;
    logic [7:0]  rx_byte;

    assign rd.rd_busy     = busy;
    assign rd.rd_val_en   = val_en;
    assign rd.rd_val_data = val_data;

    // spi clock stays low while a word waits
    assign byte_ok  = !val_en || rd.rd_ready;
    assign launch   = (state != sd_load_pkg::SPI_IDLE) && !sh_on && byte_ok;
    assign byte_end = sh_on && sd_clk && (bit_cnt == 3'd7);
    assign tx_byte  = (state == sd_load_pkg::SPI_CMD) ? cmd_sr[47:40] : 8'hFF;
    assign rx_byte  = {shift_sr[6:0], sd_miso};

    // bit engine with two sys_clk cycles per spi bit
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            sh_on    <= 1'b0;
            sd_clk   <= 1'b0;
            bit_cnt  <= 3'd0;
            shift_sr <= 8'hFF;
            sd_mosi  <= 1'b1;
        end else if (launch) begin
            sh_on    <= 1'b1;
            bit_cnt  <= 3'd0;
            shift_sr <= tx_byte;
            sd_mosi  <= tx_byte[7];             // msb set up before first rising edge
        end else if (sh_on) begin
            if (!sd_clk) begin
                sd_clk <= 1'b1;                 // card samples mosi
            end else begin
                sd_clk   <= 1'b0;               // miso captured and mosi moves on
                shift_sr <= rx_byte;
                bit_cnt  <= bit_cnt + 3'd1;
                sd_mosi  <= (bit_cnt == 3'd7) ? 1'b1 : shift_sr[6];
                if (bit_cnt == 3'd7)
                    sh_on <= 1'b0;
            end
        end
    end

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= sd_load_pkg::SPI_IDLE;
            busy     <= 1'b0;
            sd_cs    <= 1'b1;
            byte_cnt <= 10'd0;
            val_en   <= 1'b0;
        end else begin
            if (val_en && rd.rd_ready)
                val_en <= 1'b0;
            case (state)
                sd_load_pkg::SPI_IDLE: begin
                    if (rd.rd_start) begin
                        busy     <= 1'b1;
                        sd_cs    <= 1'b0;
                        byte_cnt <= 10'd0;
                        state    <= sd_load_pkg::SPI_CMD;
                    end
                end
                sd_load_pkg::SPI_CMD: begin
                    if (byte_end) begin
                        byte_cnt <= (byte_cnt == 10'd5) ? 10'd0 : byte_cnt + 10'd1;
                        if (byte_cnt == 10'd5)
                            state <= sd_load_pkg::SPI_R1;
                    end
                end
                sd_load_pkg::SPI_R1: begin
                    if (byte_end && rx_byte == 8'h00)
                        state <= sd_load_pkg::SPI_TOKEN;
                end
                sd_load_pkg::SPI_TOKEN: begin
                    if (byte_end && rx_byte == 8'hFE)
                        state <= sd_load_pkg::SPI_DATA;
                end
                sd_load_pkg::SPI_DATA: begin
                    if (byte_end) begin
                        if (byte_cnt[0])
                            val_en <= 1'b1;     // second byte completes the word
                        byte_cnt <= (byte_cnt == DATA_LAST) ? 10'd0 : byte_cnt + 10'd1;
                        if (byte_cnt == DATA_LAST)
                            state <= sd_load_pkg::SPI_CRC;
                    end
                end
                sd_load_pkg::SPI_CRC: begin
                    if (byte_end) begin
                        byte_cnt <= (byte_cnt == 10'd1) ? 10'd0 : byte_cnt + 10'd1;
                        if (byte_cnt == 10'd1)
                            state <= sd_load_pkg::SPI_GAP;
                    end
                end
                sd_load_pkg::SPI_GAP: begin
                    if (byte_end) begin
                        busy  <= 1'b0;
                        sd_cs <= 1'b1;
                        state <= sd_load_pkg::SPI_IDLE;
                    end
                end
                default: state <= sd_load_pkg::SPI_IDLE;
            endcase
        end
    end

    // command frame and word assembly
    always_ff @(posedge sys_clk) begin
        if (state == sd_load_pkg::SPI_IDLE && rd.rd_start)
            cmd_sr <= {2'b01, sd_load_pkg::CMD_READ_SINGLE, rd.rd_sec_addr, 8'h01};
        else if (launch && state == sd_load_pkg::SPI_CMD)
            cmd_sr <= {cmd_sr[39:0], 8'hFF};
        if (state == sd_load_pkg::SPI_DATA && byte_end) begin
            if (!byte_cnt[0])
                hi_byte <= rx_byte;
            else
                val_data <= {hi_byte, rx_byte};
        end
    end

    // a byte only moves inside a busy period with the card selected
    a_cs_busy: assert property (@(posedge sys_clk) disable iff (!rst_n)
        sh_on |-> (busy && !sd_cs));

    a_val_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
        (val_en && !rd.rd_ready) |=> (val_en && $stable(val_data)));

endmodule

`default_nettype wire

// File: hw/sd_read_model.sv
`timescale 1ns/1ps
`default_nettype none
`include "sd_load_defines.svh"

module sd_read_model (
    input  wire                      sys_clk,
    input  wire                      rst_n,
    sd_rd_if.loader                  rd,
    output logic                     wr_valid,
    input  wire                      wr_ready,
    output logic [`SD_ADDR_W-1:0]    wr_addr,
    output logic [15:0]              wr_data,
    output logic                     flush
);

    sd_load_pkg::load_state_e  state;
    logic [15:0]               sec_cnt;
    logic [31:0]               sec_addr;
    logic [`SD_ADDR_W-1:0]     kept_cnt;    // next memory word address
    logic                      keep;
    logic                      take;

    assign keep = (kept_cnt < `SD_MAX_WORDS);

    // past the kept count words are taken and dropped
    assign rd.rd_ready    = !keep || !wr_valid || wr_ready;
    assign rd.rd_start    = (state == sd_load_pkg::LD_REQ) && !rd.rd_busy;
    assign rd.rd_sec_addr = sec_addr;
    assign take           = rd.rd_val_en && rd.rd_ready;
    assign flush          = (state == sd_load_pkg::LD_DONE) && !wr_valid;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= sd_load_pkg::LD_IDLE;
            sec_cnt  <= 16'd0;
            sec_addr <= 32'd0;
            kept_cnt <= '0;
            wr_valid <= 1'b0;
        end else begin
            if (wr_valid && wr_ready)
                wr_valid <= 1'b0;
            if (take && keep) begin
                wr_valid <= 1'b1;
                kept_cnt <= kept_cnt + 1'b1;
            end
            case (state)
                sd_load_pkg::LD_IDLE: begin
                    sec_cnt  <= 16'd0;
                    sec_addr <= `SD_START_SEC;
                    state    <= sd_load_pkg::LD_REQ;
                end
                sd_load_pkg::LD_REQ: begin
                    if (!rd.rd_busy)
                        state <= sd_load_pkg::LD_WAIT;  // rd_start goes out this cycle
                end
                sd_load_pkg::LD_WAIT: begin
                    // busy is already up on the first wait cycle
                    if (!rd.rd_busy) begin
                        if (sec_cnt == 16'(`SD_SEC_NUM - 1)) begin
                            state <= sd_load_pkg::LD_DONE;
                        end else begin
                            sec_cnt  <= sec_cnt + 16'd1;
                            sec_addr <= sec_addr + 32'd1;
                            state    <= sd_load_pkg::LD_REQ;
                        end
                    end
                end
                sd_load_pkg::LD_DONE: state <= sd_load_pkg::LD_DONE;
                default: state <= sd_load_pkg::LD_IDLE;
            endcase
        end
    end

    // word stage towards the writer
    always_ff @(posedge sys_clk) begin
        if (take && keep) begin
            wr_addr <= kept_cnt;
            wr_data <= rd.rd_val_data;
        end
    end

    // all sectors together deliver exactly the kept words before flush
    a_flush_count: assert property (@(posedge sys_clk) disable iff (!rst_n)
        flush |-> (kept_cnt == `SD_MAX_WORDS));

endmodule

`default_nettype wire

// File: hw/burst_write_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "sd_load_defines.svh"

module burst_write_fifo (
    input  wire                      sys_clk,
    input  wire                      rst_n,
    input  wire                      wr_valid,
    output logic                     wr_ready,
    input  wire [`SD_ADDR_W-1:0]     wr_addr,
    input  wire [15:0]               wr_data,
    input  wire                      flush,
    output logic                     mem_wr_valid,
    input  wire                      mem_wr_ready,
    output logic [`SD_ADDR_W-1:0]    mem_wr_addr,
    output logic [15:0]              mem_wr_data,
    output logic                     mem_wr_last,
    output logic                     load_done
);

    localparam int PTR_W = $clog2(`SD_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`SD_FIFO_DEPTH + 1);

    sd_load_pkg::bw_state_e    state;
    logic [`SD_ADDR_W-1:0]     addr_mem [`SD_FIFO_DEPTH];
    logic [15:0]               data_mem [`SD_FIFO_DEPTH];
    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    logic [CNT_W-1:0]          count;       // occupancy
    logic [CNT_W-1:0]          beat_cnt;
    logic [CNT_W-1:0]          burst_len;   // full burst or the flush remainder
    logic                      push;
    logic                      pop;
    logic                      start;

    assign wr_ready = (count != CNT_W'(`SD_FIFO_DEPTH));
    assign push     = wr_valid && wr_ready;
    assign pop      = mem_wr_valid && mem_wr_ready;

    // short burst only for the tail after flush
    assign start = (state == sd_load_pkg::BW_IDLE) &&
                   ((count >= CNT_W'(`SD_BURST_LEN)) || (flush && count != '0));

    assign mem_wr_valid = (state == sd_load_pkg::BW_BURST);
    assign mem_wr_addr  = addr_mem[rd_ptr];     // show-ahead read
    assign mem_wr_data  = data_mem[rd_ptr];
    assign mem_wr_last  = mem_wr_valid && (beat_cnt == burst_len - 1'b1);

    always_ff @(posedge sys_clk) begin
        if (push) begin
            addr_mem[wr_ptr] <= wr_addr;
            data_mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= sd_load_pkg::BW_IDLE;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            beat_cnt  <= '0;
            burst_len <= '0;
            load_done <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;        // wraps at the power-of-two depth
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case (state)
                sd_load_pkg::BW_IDLE: begin
                    if (start) begin
                        beat_cnt  <= '0;
                        burst_len <= (count >= CNT_W'(`SD_BURST_LEN)) ?
                                     CNT_W'(`SD_BURST_LEN) : count;
                        state     <= sd_load_pkg::BW_BURST;
                    end
                end
                sd_load_pkg::BW_BURST: begin
                    if (pop) begin
                        if (mem_wr_last)
                            state <= sd_load_pkg::BW_IDLE;
                        else
                            beat_cnt <= beat_cnt + 1'b1;
                    end
                end
                default: state <= sd_load_pkg::BW_IDLE;
            endcase
            if (flush && count == '0 && state == sd_load_pkg::BW_IDLE)
                load_done <= 1'b1;              // sticky
        end
    end

    // a word refused while full is offered again unchanged
    a_full_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
        (wr_valid && !wr_ready) |=> (wr_valid && $stable(wr_addr) && $stable(wr_data)));

    a_no_pop_empty: assert property (@(posedge sys_clk) disable iff (!rst_n)
        mem_wr_valid |-> (count != '0));

endmodule

`default_nettype wire

// File: hw/sd_read_para_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "sd_load_defines.svh"

module sd_read_para_top (
    input  wire                      sys_clk,       // system clock
    input  wire                      rst_n,
    // sd card, spi mode
    input  wire                      sd_miso,
    output wire                      sd_clk,
    output wire                      sd_cs,
    output wire                      sd_mosi,
    // memory write port
    output wire                      mem_wr_valid,
    input  wire                      mem_wr_ready,
    output wire [`SD_ADDR_W-1:0]     mem_wr_addr,
    output wire [15:0]               mem_wr_data,
    output wire                      mem_wr_last,
    output wire                      load_done      // parameter block is in memory
);

    wire                    wr_valid;
    wire                    wr_ready;
    wire [`SD_ADDR_W-1:0]   wr_addr;
    wire [15:0]             wr_data;
    wire                    flush;

    sd_rd_if rd_bus ();

    sd_spi_reader u_sd_spi_reader (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .rd           (rd_bus.reader),
        .sd_miso      (sd_miso),
        .sd_clk       (sd_clk),
        .sd_cs        (sd_cs),
        .sd_mosi      (sd_mosi)
    );

    sd_read_model u_sd_read_model (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .rd           (rd_bus.loader),
        .wr_valid     (wr_valid),
        .wr_ready     (wr_ready),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .flush        (flush)
    );

    burst_write_fifo u_burst_write_fifo (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .wr_valid     (wr_valid),
        .wr_ready     (wr_ready),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .flush        (flush),
        .mem_wr_valid (mem_wr_valid),
        .mem_wr_ready (mem_wr_ready),
        .mem_wr_addr  (mem_wr_addr),
        .mem_wr_data  (mem_wr_data),
        .mem_wr_last  (mem_wr_last),
        .load_done    (load_done)
    );

endmodule

`default_nettype wire

// File: verification/sd_card_model.sv
`timescale 1ns/1ps
`default_nettype none
`include "sd_load_defines.svh"

module sd_card_model (
    input  wire         sd_clk,
    input  wire         sd_cs,
    input  wire         sd_mosi,
    output logic        sd_miso,
    output logic [7:0]  cmd_byte,           // first byte of the latest frame
    output logic [31:0] cmd_arg,            // its argument, the sector address
    output logic [7:0]  cmd_count           // frames decoded so far
);

    logic [47:0] frame_sr;
    logic [7:0]  out_sr;
    int          bit_cnt;
    int          out_cnt;
    bit          resp_on;                   // command taken, card is talking
    logic [7:0]  resp_q [$];

    // byte i of sector sec
    function automatic logic [7:0] sector_byte(input logic [31:0] sec, input int i);
        return 8'(sec * 7 + i * 3);
    endfunction

    task automatic queue_read(input logic [31:0] sec);
        int n_wait;
        n_wait = 2 + sec[1:0];              // 2 to 5 bytes before r1
        repeat (n_wait)
            resp_q.push_back(8'hFF);
        resp_q.push_back(8'h00);            // r1, no error
        repeat (1 + sec[0])
            resp_q.push_back(8'hFF);        // access time filler
        resp_q.push_back(8'hFE);
        for (int i = 0; i < 2 * `SD_SECTOR_WORDS; i++)
            resp_q.push_back(sector_byte(sec, i));
        resp_q.push_back(8'hA5);            // crc bytes, nobody checks them
        resp_q.push_back(8'h5A);
    endtask

    initial begin
        sd_miso   = 1'b1;
        cmd_byte  = 8'h00;
        cmd_arg   = 32'h0;
        cmd_count = 8'd0;
        bit_cnt   = 0;
        out_cnt   = 0;
        resp_on   = 1'b0;
    end

    // mode 0, mosi sampled on the rising edge
    always @(posedge sd_clk) begin
        if (!sd_cs && !resp_on) begin
            frame_sr = {frame_sr[46:0], sd_mosi};
            bit_cnt  = bit_cnt + 1;
            if (bit_cnt == 48) begin
                bit_cnt   = 0;
                cmd_byte  = frame_sr[47:40];
                cmd_arg   = frame_sr[39:8];
                cmd_count = cmd_count + 8'd1;
                if (frame_sr[47:40] == 8'h51) begin
                    queue_read(frame_sr[39:8]);
                    resp_on = 1'b1;
                end
            end
        end
    end

    // miso moves on the falling edge
    always @(negedge sd_clk) begin
        if (resp_on) begin
            if (out_cnt == 0) begin
                if (resp_q.size() > 0)
                    out_sr = resp_q.pop_front();
                else
                    out_sr = 8'hFF;
            end
            sd_miso <= out_sr[7];
            out_sr  = {out_sr[6:0], 1'b1};
            out_cnt = (out_cnt + 1) % 8;
        end
    end

    // deselect ends the transaction
    always @(posedge sd_cs) begin
        resp_on = 1'b0;
        bit_cnt = 0;
        out_cnt = 0;
        resp_q.delete();
        sd_miso <= 1'b1;
    end

endmodule

`default_nettype wire

// File: verification/sd_read_para_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "sd_load_defines.svh"

module sd_read_para_tb;

    // stall-free load is about 3 x 530 bytes x 17 cycles or 27k cycles
    localparam int TIMEOUT_CYCLES = 300000;

    logic                    sys_clk;
    logic                    rst_n;
    logic                    mem_wr_ready;
    wire                     sd_miso;
    wire                     sd_clk;
    wire                     sd_cs;
    wire                     sd_mosi;
    wire                     mem_wr_valid;
    wire [`SD_ADDR_W-1:0]    mem_wr_addr;
    wire [15:0]              mem_wr_data;
    wire                     mem_wr_last;
    wire                     load_done;
    wire [7:0]               card_cmd_byte;
    wire [31:0]              card_cmd_arg;
    wire [7:0]               card_cmd_count;

    logic [15:0]             exp_mem [`SD_MAX_WORDS];   // expected memory image
    logic [31:0]             rng;
    int                      cycles;
    int                      writes;                    // accepted memory writes
    int                      cmds_seen;
    logic                    held;                      // stalled beat last negedge
    logic [`SD_ADDR_W-1:0]   held_addr;
    logic [15:0]             held_data;
    logic                    held_last;

    sd_read_para_top sd_read_para_top_i (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .sd_miso      (sd_miso),
        .sd_clk       (sd_clk),
        .sd_cs        (sd_cs),
        .sd_mosi      (sd_mosi),
        .mem_wr_valid (mem_wr_valid),
        .mem_wr_ready (mem_wr_ready),
        .mem_wr_addr  (mem_wr_addr),
        .mem_wr_data  (mem_wr_data),
        .mem_wr_last  (mem_wr_last),
        .load_done    (load_done)
    );

    sd_card_model sd_card_model_i (
        .sd_clk    (sd_clk),
        .sd_cs     (sd_cs),
        .sd_mosi   (sd_mosi),
        .sd_miso   (sd_miso),
        .cmd_byte  (card_cmd_byte),
        .cmd_arg   (card_cmd_arg),
        .cmd_count (card_cmd_count)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // word a is bytes 2j and 2j + 1 of sector start + a / 256 with msb first
    function automatic logic [15:0] expected_word(input int a);
        logic [31:0] sec;
        int          j;
        sec = `SD_START_SEC + a / `SD_SECTOR_WORDS;
        j   = 2 * (a % `SD_SECTOR_WORDS);
        return {8'(sec * 7 + j * 3), 8'(sec * 7 + (j + 1) * 3)};
    endfunction

    task automatic stop_on_error;
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    always #10 sys_clk = ~sys_clk;

    always @(posedge sys_clk)
        cycles <= cycles + 1;

    // ready high on about 70% of the cycles
    always @(posedge sys_clk) begin
        #1;
        rng = xorshift(rng);
        mem_wr_ready = (rng % 100) < 70;
    end

    // sampled mid-cycle so a beat seen here transfers at the next rising edge
    always @(negedge sys_clk) begin : port_monitor
        logic exp_last;
        if (rst_n) begin
            if (card_cmd_count != 8'(cmds_seen)) begin
                assert (cmds_seen < `SD_SEC_NUM)
                else begin
                    $display("card received more read commands than sectors to load");
                    stop_on_error();
                end
                assert (card_cmd_byte == 8'h51)
                else begin
                    $display("[FAIL] %0t card_cmd_byte got %h expected %h",
                             $time, card_cmd_byte, 8'h51);
                    stop_on_error();
                end
                assert (card_cmd_arg == `SD_START_SEC + cmds_seen)
                else begin
                    $display("[FAIL] %0t card_cmd_arg got %h expected %h",
                             $time, card_cmd_arg, `SD_START_SEC + cmds_seen);
                    stop_on_error();
                end
                cmds_seen = cmds_seen + 1;
            end
            if (held) begin
                assert (mem_wr_valid && mem_wr_addr == held_addr &&
                        mem_wr_data == held_data && mem_wr_last == held_last)
                else begin
                    $display("[FAIL] %0t mem_wr_valid/addr/data/last got %b/%h/%h/%b %s %h/%h/%b",
                             $time, mem_wr_valid, mem_wr_addr, mem_wr_data, mem_wr_last,
                             "expected 1 held", held_addr, held_data, held_last);
                    stop_on_error();
                end
            end
            if (load_done) begin
                assert (writes == `SD_MAX_WORDS && cmds_seen == `SD_SEC_NUM)
                else begin
                    $display("load_done rose after %0d of %0d writes and %0d of %0d reads",
                             writes, `SD_MAX_WORDS, cmds_seen, `SD_SEC_NUM);
                    stop_on_error();
                end
            end
            if (mem_wr_valid && mem_wr_ready) begin
                assert (!load_done && writes < `SD_MAX_WORDS)
                else begin
                    $display("memory write accepted after the last word or after load_done");
                    stop_on_error();
                end
                assert (mem_wr_addr == writes)
                else begin
                    $display("[FAIL] %0t mem_wr_addr got %0d expected %0d",
                             $time, mem_wr_addr, writes);
                    stop_on_error();
                end
                assert (mem_wr_data == exp_mem[writes])
                else begin
                    $display("[FAIL] %0t mem_wr_data got %h expected %h",
                             $time, mem_wr_data, exp_mem[writes]);
                    stop_on_error();
                end
                exp_last = ((writes + 1) % `SD_BURST_LEN == 0) || (writes == `SD_MAX_WORDS - 1);
                assert (mem_wr_last == exp_last)
                else begin
                    $display("[FAIL] %0t mem_wr_last got %b expected %b",
                             $time, mem_wr_last, exp_last);
                    stop_on_error();
                end
                writes = writes + 1;
            end
            held      = mem_wr_valid && !mem_wr_ready;
            held_addr = mem_wr_addr;
            held_data = mem_wr_data;
            held_last = mem_wr_last;
        end
    end

    initial begin
        sys_clk      = 1'b0;
        rst_n        = 1'b0;
        mem_wr_ready = 1'b0;
        rng          = 32'h6f55_1044;
        cycles       = 0;
        writes       = 0;
        cmds_seen    = 0;
        held         = 1'b0;
        for (int a = 0; a < `SD_MAX_WORDS; a++)
            exp_mem[a] = expected_word(a);
        repeat (5) @(posedge sys_clk);
        #1 rst_n = 1'b1;
        while (!load_done && cycles < TIMEOUT_CYCLES)
            @(posedge sys_clk);
        repeat (20) @(posedge sys_clk);     // watch the port stay quiet after done
        if (!load_done) begin
            $display("timeout, load_done not seen after %0d cycles", cycles);
            stop_on_error();
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sd_read_para_top.f
+incdir+include
hw/sd_load_pkg.sv
hw/sd_rd_if.sv
hw/sd_spi_reader.sv
hw/sd_read_model.sv
hw/burst_write_fifo.sv
hw/sd_read_para_top.sv
verification/sd_card_model.sv
verification/sd_read_para_tb.sv
